/* files.f */
+incdir+verilog
+incdir+tb
verilog/frame_buf_pkg.sv
verilog/frame_buf_if.sv
verilog/frame_in_fifo.sv
verilog/burst_writer.sv
verilog/frame_ptr_ctrl.sv
verilog/wr_cmd_gen.sv
verilog/frame_buf_wr.sv
tb/tb_clk_gen.sv
tb/tb_frame_buf_wr.sv

/* Bender.yml */
package:
  name: frame_buf_wr

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/frame_buf_pkg.sv
      - verilog/frame_buf_if.sv
      - verilog/frame_in_fifo.sv
      - verilog/burst_writer.sv
      - verilog/frame_ptr_ctrl.sv
      - verilog/wr_cmd_gen.sv
      - verilog/frame_buf_wr.sv
  - target: test
    include_dirs:
      - verilog
      - tb
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_frame_buf_wr.sv

/* tb/frame_buf_model.svh */
// reference model of the frame buffer write side
// front FIFO contents, burst bookkeeping and frame slot choice

`ifndef FRAME_BUF_MODEL_SVH
`define FRAME_BUF_MODEL_SVH

// ----------------------------------------
// model state
// ----------------------------------------
// accepted words not yet written in arrival order
fifo_word_t exp_q[$];
// stream latch, last fval, sticky overflow
logic       m_stream;
logic       m_fval_q;
logic       m_overflow;
// depth as held by the pointer block
int         m_depth;
int         m_ptr;
// reader state at the previous edge
logic       m_reading_q;
int         m_rd_ptr_q;
// open burst
int         m_burst_words;
seg_kind_t  m_burst_seg;
// commands so far in this frame
int         m_cmd_idx;

// step to the next slot and back to 0 past the last one
function automatic int wrap_next(input int p, input int depth);
	if (p + 1 >= depth)
		return 0;
	return p + 1;
endfunction

// slot for a new frame, stepping over the one under read
function automatic int choose_slot(input int p, input int depth, input logic reading,
	input int rd_ptr);
	int c;
	if (depth <= 1)
		return 0;
	c = wrap_next(p, depth);
	if (reading && (c == rd_ptr))
		c = wrap_next(c, depth);
	return c;
endfunction

task automatic model_reset();
	exp_q.delete();
	m_stream      = 1'b0;
	m_fval_q      = 1'b0;
	m_overflow    = 1'b0;
	m_depth       = 1;
	m_ptr         = 0;
	m_reading_q   = 1'b0;
	m_rd_ptr_q    = 0;
	m_burst_words = 0;
	m_burst_seg   = SEG_LEADER;
	m_cmd_idx     = 0;
endtask

// pointer side of one clock edge
task automatic model_ptr_edge(input int depth, input logic reading, input int rd_ptr);
	// back to slot 0 while stopped or with a single slot
	if (!m_stream || (m_depth <= 1))
		m_ptr = 0;
	m_depth     = depth;
	m_reading_q = reading;
	m_rd_ptr_q  = rd_ptr;
endtask

// input side of one clock edge
// full is the buffer state before this edge
task automatic model_input_edge(input logic full, input logic fval, input logic dval,
	input logic enable, input seg_kind_t seg, input logic [`FB_DATA_W-1:0] data);
	logic       rise;
	logic       on;
	fifo_word_t w;
	rise = fval && !m_fval_q;
	// enable counts at a frame start only and drops at once
	on   = enable && (m_stream || rise);
	if (rise)
		m_overflow = 1'b0;
	else if (dval && full)
		m_overflow = 1'b1;
	// new frame or stopped stream empties the buffer
	if (rise || !m_stream)
		exp_q.delete();
	if (fval && dval && !full && on) begin
		w.seg  = seg;
		w.data = data;
		exp_q.push_back(w);
	end
	m_fval_q = fval;
	m_stream = on;
endtask

`endif

/* tb/tb_frame_buf_wr.sv */
// testbench for the frame buffer write side
// random frames against a reference model of data, bursts, addresses and slots

`include "frame_buf_cfg.svh"

module tb_frame_buf_wr import frame_buf_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD    = 4;
	localparam int N_RANDOM      = 20;
	localparam int N_FRAMES      = N_RANDOM + 10;
	localparam int MAX_FRAME_LEN = 300;
	localparam int DRAIN_LIMIT   = 5000;

	logic                       clk;
	logic                       reset;
	logic                       i_fval;
	logic                       i_dval;
	logic                       i_leader_flag;
	logic                       i_image_flag;
	logic                       i_chunk_flag;
	logic                       i_trailer_flag;
	logic [`FB_DATA_W-1:0]      iv_image_din;
	logic                       i_stream_enable;
	logic [`FB_PTR_W:0]         iv_frame_depth;
	logic [`FB_PTR_W-1:0]       iv_rd_ptr;
	logic                       i_reading;
	logic                       i_wr_cmd_full;
	logic                       i_wr_full;
	logic                       o_buf_full;
	logic                       o_buf_overflow;
	logic [`FB_PTR_W-1:0]       ov_wr_ptr;
	logic                       o_wr_ptr_change;
	logic                       o_writing;
	logic                       o_wr_cmd_en;
	logic [`FB_BL_W-1:0]        ov_wr_cmd_bl;
	logic [`FB_BYTE_ADDR_W-1:0] ov_wr_cmd_byte_addr;
	logic                       o_wr_en;
	logic [`FB_DATA_W-1:0]      ov_wr_data;

	int        err_cnt;
	int        test_err_start;
	int        n_words;
	int        n_cmds;
	int        n_changes;
	int        n_frames;
	int        run_left;
	seg_kind_t cur_seg;
	bit        after_reset;
	bit        seen_full;
	bit        seen_overflow;

	`include "frame_buf_model.svh"

	tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) tb_clk_gen_inst (
		.clk   (clk),
		.reset (reset)
	);

	frame_buf_wr frame_buf_wr_inst (
		.clk                 (clk),
		.reset               (reset),
		.i_fval              (i_fval),
		.i_dval              (i_dval),
		.i_leader_flag       (i_leader_flag),
		.i_image_flag        (i_image_flag),
		.i_chunk_flag        (i_chunk_flag),
		.i_trailer_flag      (i_trailer_flag),
		.iv_image_din        (iv_image_din),
		.i_stream_enable     (i_stream_enable),
		.iv_frame_depth      (iv_frame_depth),
		.iv_rd_ptr           (iv_rd_ptr),
		.i_reading           (i_reading),
		.i_wr_cmd_full       (i_wr_cmd_full),
		.i_wr_full           (i_wr_full),
		.o_buf_full          (o_buf_full),
		.o_buf_overflow      (o_buf_overflow),
		.ov_wr_ptr           (ov_wr_ptr),
		.o_wr_ptr_change     (o_wr_ptr_change),
		.o_writing           (o_writing),
		.o_wr_cmd_en         (o_wr_cmd_en),
		.ov_wr_cmd_bl        (ov_wr_cmd_bl),
		.ov_wr_cmd_byte_addr (ov_wr_cmd_byte_addr),
		.o_wr_en             (o_wr_en),
		.ov_wr_data          (ov_wr_data)
	);

	// ----------------------------------------
	// reporting
	// ----------------------------------------
	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
		err_cnt++;
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		err_cnt++;
	endtask

	task automatic end_test(input string name);
		$display("test %s done: frames %0d, words %0d, errors %0d", name, n_frames, n_words,
			err_cnt - test_err_start);
		test_err_start = err_cnt;
	endtask

	// ----------------------------------------
	// stimulus driven on the falling edge
	// ----------------------------------------
	task automatic drive_flags(input seg_kind_t s);
		i_leader_flag  = (s == SEG_LEADER);
		i_image_flag   = (s == SEG_IMAGE);
		i_chunk_flag   = (s == SEG_CHUNK);
		i_trailer_flag = (s == SEG_TRAILER);
	endtask

	// memory side stalls and reader state
	task automatic drive_backpressure(input bit hold_full);
		i_wr_full     = hold_full || ($urandom_range(7, 0) == 0);
		i_wr_cmd_full = ($urandom_range(3, 0) == 0);
		i_reading     = $urandom_range(1, 0);
		if ($urandom_range(7, 0) == 0)
			iv_rd_ptr = $urandom_range(3, 0);
	endtask

	task automatic idle_cycles(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			@(negedge clk);
			i_fval = 1'b0;
			i_dval = 1'b0;
			drive_backpressure(1'b0);
		end
	endtask

	// one frame where hold_full stalls the write port and keeps dval high
	task automatic frame_cycles(input int n_cycles, input bit hold_full);
		int i;
		for (i = 0; i < n_cycles; i++) begin
			@(negedge clk);
			if (run_left == 0) begin
				cur_seg  = seg_kind_t'($urandom_range(3, 0));
				run_left = $urandom_range(40, 1);
			end
			i_fval       = 1'b1;
			i_dval       = hold_full || ($urandom_range(3, 0) != 0);
			iv_image_din = {$urandom, $urandom};
			drive_flags(cur_seg);
			drive_backpressure(hold_full);
			if (i_dval)
				run_left--;
		end
		@(negedge clk);
		i_fval = 1'b0;
		i_dval = 1'b0;
		drive_backpressure(1'b0);
		n_frames++;
	endtask

	// all words out, last command issued, frame flag down
	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || o_writing || m_burst_words != 0) && n < DRAIN_LIMIT) begin
			@(negedge clk);
			drive_backpressure(1'b0);
			n++;
		end
		if (n >= DRAIN_LIMIT)
			report_failure("frame did not drain: words or a command still pending");
	endtask

	// ----------------------------------------
	// monitor and checks at the rising edge
	// ----------------------------------------
	always @(posedge clk) begin : monitor
		cmd_addr_u  addr;
		fifo_word_t head;
		int         exp_slot;
		logic       was_full;
		if (reset) begin
			model_reset();
			after_reset = 1'b1;
		end else begin
			// buffer state before this edge
			was_full = (exp_q.size() == `FB_FIFO_DEPTH);
			if (after_reset) begin
				assert (!o_wr_en && !o_wr_cmd_en && !o_wr_ptr_change && !o_writing
					&& !o_buf_overflow)
				else report_failure("outputs not cleared after reset");
			end
			after_reset = 1'b0;
			if (o_buf_full)
				seen_full = 1'b1;
			if (o_buf_overflow)
				seen_overflow = 1'b1;
			assert (o_buf_full == was_full)
			else report_mismatch("o_buf_full", o_buf_full, was_full);
			assert (o_buf_overflow == m_overflow)
			else report_mismatch("o_buf_overflow", o_buf_overflow, m_overflow);
			assert (!(o_wr_en && o_wr_cmd_en))
			else report_failure("o_wr_en and o_wr_cmd_en high in the same cycle");
			// data path in order and once
			if (o_wr_en) begin
				n_words++;
				assert (o_writing) else report_failure("o_wr_en while o_writing is low");
				assert (exp_q.size() != 0)
				else report_failure("o_wr_en with no accepted word pending");
				if (exp_q.size() != 0) begin
					head = exp_q.pop_front();
					assert (ov_wr_data === head.data)
					else report_mismatch("ov_wr_data", ov_wr_data, head.data);
					if (m_burst_words == 0)
						m_burst_seg = head.seg;
					else
						assert (head.seg == m_burst_seg)
						else report_mismatch("burst segment", head.seg, m_burst_seg);
					m_burst_words++;
				end
			end
			// command closes the open burst
			if (o_wr_cmd_en) begin
				addr.flat = ov_wr_cmd_byte_addr;
				assert (m_burst_words > 0)
				else report_failure("write command with no burst data before it");
				assert (ov_wr_cmd_bl == m_burst_words - 1)
				else report_mismatch("ov_wr_cmd_bl", ov_wr_cmd_bl, m_burst_words - 1);
				assert (ov_wr_cmd_bl <= `FB_BURST_LEN - 1)
				else report_mismatch("ov_wr_cmd_bl", ov_wr_cmd_bl, `FB_BURST_LEN - 1);
				assert (addr.f.slot == m_ptr)
				else report_mismatch("ov_wr_cmd_byte_addr slot", addr.f.slot, m_ptr);
				assert (addr.f.slot == ov_wr_ptr)
				else report_mismatch("ov_wr_cmd_byte_addr slot", addr.f.slot, ov_wr_ptr);
				assert (addr.f.burst_idx == m_cmd_idx)
				else report_mismatch("ov_wr_cmd_byte_addr burst", addr.f.burst_idx, m_cmd_idx);
				assert (addr.f.offset == '0)
				else report_mismatch("ov_wr_cmd_byte_addr offset", addr.f.offset, 0);
				m_cmd_idx++;
				m_burst_words = 0;
				n_cmds++;
			end
			// reader state sampled at the grant edge
			if (o_wr_ptr_change) begin
				exp_slot = choose_slot(m_ptr, m_depth, m_reading_q, m_rd_ptr_q);
				assert (ov_wr_ptr == exp_slot)
				else report_mismatch("ov_wr_ptr", ov_wr_ptr, exp_slot);
				if (m_depth <= 1)
					assert (!m_reading_q)
					else report_failure("frame started with one slot while the reader held it");
				assert (o_writing) else report_failure("o_writing low at the pointer change");
				m_ptr     = exp_slot;
				m_cmd_idx = 0;
				n_changes++;
			end
			model_ptr_edge(iv_frame_depth, i_reading, iv_rd_ptr);
			model_input_edge(was_full, i_fval, i_dval, i_stream_enable, cur_seg,
				iv_image_din);
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin : stimulus
		int f;
		int words_before;
		bit en;
		err_cnt         = 0;
		test_err_start  = 0;
		n_words         = 0;
		n_cmds          = 0;
		n_changes       = 0;
		n_frames        = 0;
		run_left        = 0;
		cur_seg         = SEG_LEADER;
		after_reset     = 1'b0;
		seen_full       = 1'b0;
		seen_overflow   = 1'b0;
		i_fval          = 1'b0;
		i_dval          = 1'b0;
		drive_flags(SEG_LEADER);
		iv_image_din    = '0;
		i_stream_enable = 1'b1;
		iv_frame_depth  = 4;
		iv_rd_ptr       = '0;
		i_reading       = 1'b0;
		i_wr_cmd_full   = 1'b0;
		i_wr_full       = 1'b0;
		void'($urandom(32'h8fc0_7941));
		wait (reset == 1'b0);
		idle_cycles(4);

		// random frames over all depths
		for (f = 0; f < N_RANDOM; f++) begin
			iv_frame_depth = $urandom_range(4, 1);
			frame_cycles($urandom_range(200, 1), 1'b0);
			wait_drain();
			idle_cycles($urandom_range(8, 2));
		end
		end_test("random frames");

		// single slot with the reader busy half the time
		iv_frame_depth = 1;
		for (f = 0; f < 4; f++) begin
			frame_cycles($urandom_range(150, 20), 1'b0);
			wait_drain();
			idle_cycles($urandom_range(8, 2));
		end
		end_test("depth one");

		// every other frame starts with the stream off
		for (f = 0; f < 4; f++) begin
			iv_frame_depth  = $urandom_range(4, 1);
			en              = (f % 2 == 1);
			i_stream_enable = en;
			words_before    = n_words;
			frame_cycles($urandom_range(150, 20), 1'b0);
			wait_drain();
			if (!en)
				assert (n_words == words_before)
				else report_failure("frame started with the stream off was written");
			i_stream_enable = 1'b1;
			idle_cycles($urandom_range(8, 2));
		end
		end_test("stream enable");

		// stalled write port fills the front FIFO
		seen_full     = 1'b0;
		seen_overflow = 1'b0;
		frame_cycles(MAX_FRAME_LEN, 1'b1);
		wait_drain();
		assert (seen_full) else report_failure("o_buf_full never rose with the write port stalled");
		assert (seen_overflow) else report_failure("o_buf_overflow never rose on a full FIFO");
		idle_cycles(4);
		// next frame start clears the flag
		frame_cycles($urandom_range(100, 10), 1'b0);
		wait_drain();
		idle_cycles(4);
		end_test("overflow");

		$display("summary: frames %0d, words %0d, commands %0d, pointer changes %0d, errors %0d",
			n_frames, n_words, n_cmds, n_changes, err_cnt);
		if (err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// bound on the whole run
	initial begin : watchdog
		#(N_FRAMES * MAX_FRAME_LEN * 20 * CLK_PERIOD);
		$display("ERROR t=%0t watchdog expired before the tests finished", $time);
		$display("Something failed");
		$finish;
	end

endmodule

/* tb/tb_clk_gen.sv */
// testbench clock and reset
// free running clock, reset held for the first cycles

module tb_clk_gen #(
	parameter int PERIOD       = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release away from the active edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* verilog/frame_buf_wr.sv */
// frame buffer write side, top level
// front FIFO, burst writer, frame pointer and command generator

`include "frame_buf_cfg.svh"

module frame_buf_wr import frame_buf_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_fval,
	input  logic                       i_dval,
	input  logic                       i_leader_flag,
	input  logic                       i_image_flag,
	input  logic                       i_chunk_flag,
	input  logic                       i_trailer_flag,
	input  logic [`FB_DATA_W-1:0]      iv_image_din,
	input  logic                       i_stream_enable,
	input  logic [`FB_PTR_W:0]         iv_frame_depth,
	input  logic [`FB_PTR_W-1:0]       iv_rd_ptr,
	input  logic                       i_reading,
	input  logic                       i_wr_cmd_full,
	input  logic                       i_wr_full,
	output logic                       o_buf_full,
	output logic                       o_buf_overflow,
	output logic [`FB_PTR_W-1:0]       ov_wr_ptr,
	output logic                       o_wr_ptr_change,
	output logic                       o_writing,
	output logic                       o_wr_cmd_en,
	output logic [`FB_BL_W-1:0]        ov_wr_cmd_bl,
	output logic [`FB_BYTE_ADDR_W-1:0] ov_wr_cmd_byte_addr,
	output logic                       o_wr_en,
	output logic [`FB_DATA_W-1:0]      ov_wr_data
);
	seg_kind_t seg_kind;
	logic      ptr_req;
	logic      ptr_ack;

	fifo_rd_if fifo_if ();
	burst_if   bus_if ();

	// one-hot flags to segment kind, image when none set
	always_comb begin
		case ({i_trailer_flag, i_chunk_flag, i_image_flag, i_leader_flag})
			4'b0001: seg_kind = SEG_LEADER;
			4'b0100: seg_kind = SEG_CHUNK;
			4'b1000: seg_kind = SEG_TRAILER;
			default: seg_kind = SEG_IMAGE;
		endcase
	end

	frame_in_fifo frame_in_fifo_inst (
		.clk             (clk),
		.reset           (reset),
		.i_fval          (i_fval),
		.i_dval          (i_dval),
		.i_seg           (seg_kind),
		.i_data          (iv_image_din),
		.i_stream_enable (i_stream_enable),
		.o_full          (o_buf_full),
		.o_overflow      (o_buf_overflow),
		.rd              (fifo_if.producer)
	);

	burst_writer burst_writer_inst (
		.clk       (clk),
		.reset     (reset),
		.i_wr_full (i_wr_full),
		.i_ptr_ack (ptr_ack),
		.o_ptr_req (ptr_req),
		.o_wr_en   (o_wr_en),
		.o_wr_data (ov_wr_data),
		.rd        (fifo_if.consumer),
		.bus       (bus_if.writer)
	);

	// stream state comes from the FIFO latch
	frame_ptr_ctrl frame_ptr_ctrl_inst (
		.clk             (clk),
		.reset           (reset),
		.i_ptr_req       (ptr_req),
		.iv_rd_ptr       (iv_rd_ptr),
		.i_reading       (i_reading),
		.iv_frame_depth  (iv_frame_depth),
		.i_stream_on     (fifo_if.stream_on),
		.o_ptr_ack       (ptr_ack),
		.ov_wr_ptr       (ov_wr_ptr),
		.o_wr_ptr_change (o_wr_ptr_change)
	);

	wr_cmd_gen wr_cmd_gen_inst (
		.clk                 (clk),
		.reset               (reset),
		.iv_wr_ptr           (ov_wr_ptr),
		.i_wr_cmd_full       (i_wr_cmd_full),
		.o_wr_cmd_en         (o_wr_cmd_en),
		.ov_wr_cmd_bl        (ov_wr_cmd_bl),
		.ov_wr_cmd_byte_addr (ov_wr_cmd_byte_addr),
		.o_writing           (o_writing),
		.bus                 (bus_if.issuer)
	);

endmodule

/* verilog/wr_cmd_gen.sv */
// write command generator
// forms burst length and byte address, runs the writing flag

`include "frame_buf_cfg.svh"

module wr_cmd_gen import frame_buf_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`FB_PTR_W-1:0]       iv_wr_ptr,
	input  logic                       i_wr_cmd_full,
	output logic                       o_wr_cmd_en,
	output logic [`FB_BL_W-1:0]        ov_wr_cmd_bl,
	output logic [`FB_BYTE_ADDR_W-1:0] ov_wr_cmd_byte_addr,
	output logic                       o_writing,
	burst_if.issuer                    bus
);
	logic [BURST_IDX_W-1:0] burst_idx;
	logic [`FB_BL_W-1:0]    bl_q;
	cmd_addr_u              addr_q;
	logic                   issue;
	logic                   cmd_en_q;
	logic                   writing_q;

	// first free cycle with a pending burst
	assign issue = bus.req && !i_wr_cmd_full && !cmd_en_q;

	always_ff @(posedge clk) begin
		if (reset)
			cmd_en_q <= 1'b0;
		else
			cmd_en_q <= issue;
	end

	// command payload
	always_ff @(posedge clk) begin
		if (issue) begin
			bl_q                <= bus.len;
			addr_q.f.slot       <= iv_wr_ptr;
			addr_q.f.burst_idx  <= burst_idx;
			addr_q.f.offset     <= '0;
		end
	end

	// bursts within the frame
	always_ff @(posedge clk) begin
		if (reset || bus.frame_start)
			burst_idx <= '0;
		else if (cmd_en_q)
			burst_idx <= burst_idx + 1'b1;
	end

	// ----------------------------------------
	// writing flag
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			writing_q <= 1'b0;
		else if (bus.frame_start)
			writing_q <= 1'b1;
		else if (bus.frame_done)
			writing_q <= 1'b0;
	end

	// up with the pointer change, down with the last command
	assign o_writing = (writing_q | bus.frame_start) & ~bus.frame_done;

	assign bus.ack             = cmd_en_q;
	assign o_wr_cmd_en         = cmd_en_q;
	assign ov_wr_cmd_bl        = bl_q;
	assign ov_wr_cmd_byte_addr = addr_q.flat;

endmodule

/* verilog/frame_ptr_ctrl.sv */
// frame pointer control
// picks the write slot per frame, skips the slot under read

`include "frame_buf_cfg.svh"

module frame_ptr_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_ptr_req,
	input  logic [`FB_PTR_W-1:0] iv_rd_ptr,
	input  logic                 i_reading,
	input  logic [`FB_PTR_W:0]   iv_frame_depth,
	input  logic                 i_stream_on,
	output logic                 o_ptr_ack,
	output logic [`FB_PTR_W-1:0] ov_wr_ptr,
	output logic                 o_wr_ptr_change
);
	logic [`FB_PTR_W:0]   depth_q;
	logic [`FB_PTR_W-1:0] wr_ptr;
	logic [`FB_PTR_W-1:0] cand_a;
	logic [`FB_PTR_W-1:0] cand_b;
	logic                 single;
	logic                 hold;
	logic                 grant;
	logic                 ack_q;

	// next slot, wraps from depth-1 back to 0
	function automatic logic [`FB_PTR_W-1:0] next_slot(
		input logic [`FB_PTR_W-1:0] p,
		input logic [`FB_PTR_W:0]   depth
	);
		logic [`FB_PTR_W:0] p_ext;
		p_ext = {1'b0, p};
		if (p_ext + 1'b1 >= depth)
			return '0;
		return p + 1'b1;
	endfunction

	// ----------------------------------------
	// candidate and skip
	// ----------------------------------------
	assign single = (depth_q <= 1);
	// one slot and it is being read, wait
	assign hold   = single && i_reading;
	assign grant  = i_ptr_req && !ack_q && !hold;
	assign cand_a = next_slot(wr_ptr, depth_q);
	// step over the reader once
	assign cand_b = (i_reading && (cand_a == iv_rd_ptr)) ? next_slot(cand_a, depth_q) : cand_a;

	// depth only follows the input between requests
	always_ff @(posedge clk) begin
		if (reset)
			depth_q <= 1;
		else if (!i_ptr_req)
			depth_q <= iv_frame_depth;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= grant;
	end

	always_ff @(posedge clk) begin
		if (reset || !i_stream_on || single)
			wr_ptr <= '0;
		else if (grant)
			wr_ptr <= cand_b;
	end

	assign o_ptr_ack       = ack_q;
	assign o_wr_ptr_change = ack_q;
	assign ov_wr_ptr       = wr_ptr;

	// chosen slot lies inside the frame depth
	a_ptr_range: assert property (@(posedge clk) disable iff (reset)
		o_ptr_ack |-> ((ov_wr_ptr == '0) || ({1'b0, ov_wr_ptr} < depth_q)));

endmodule

/* verilog/burst_writer.sv */
// burst writer FSM
// moves front FIFO words to the memory write port and closes bursts

`include "frame_buf_cfg.svh"

module burst_writer import frame_buf_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_wr_full,
	input  logic                  i_ptr_ack,
	output logic                  o_ptr_req,
	output logic                  o_wr_en,
	output logic [`FB_DATA_W-1:0] o_wr_data,
	fifo_rd_if.consumer           rd,
	burst_if.writer               bus
);
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_PTR  = 2'd1;
	localparam logic [1:0] S_WR   = 2'd2;
	localparam logic [1:0] S_CMD  = 2'd3;

	logic [1:0]          state;
	logic [1:0]          state_nxt;
	// words in the open burst (up to 32)
	logic [`FB_BL_W-1:0] wcnt;
	seg_kind_t           burst_seg;
	logic                seg_break;
	logic                frame_end;
	logic                end_cond;
	logic                take;
	logic                last_word;

	// ----------------------------------------
	// burst close conditions
	// ----------------------------------------
	// head word belongs to another flag segment
	assign seg_break = (wcnt != '0) && !rd.empty && (rd.word.seg != burst_seg);
	// frame over and nothing left
	assign frame_end = !rd.frame_active && rd.empty;
	assign end_cond  = !rd.stream_on || frame_end;

	// one word per cycle while allowed
	assign take      = (state == S_WR) && rd.stream_on && !rd.empty && !i_wr_full
		&& !seg_break;
	assign last_word = take && (wcnt == `FB_BURST_LEN - 1);

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				// threshold reached, or a short frame already ended
				if (rd.stream_on && (rd.level_ok || (!rd.frame_active && !rd.empty)))
					state_nxt = S_PTR;
			end
			S_PTR: begin
				if (i_ptr_ack)
					state_nxt = S_WR;
			end
			S_WR: begin
				if (end_cond)
					state_nxt = (wcnt == '0) ? S_IDLE : S_CMD;
				else if (last_word || seg_break)
					state_nxt = S_CMD;
			end
			S_CMD: begin
				if (bus.ack)
					state_nxt = end_cond ? S_IDLE : S_WR;
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	// ----------------------------------------
	// burst word count and segment
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			wcnt <= '0;
		else if ((state == S_CMD) && bus.ack)
			wcnt <= '0;
		else if (take)
			wcnt <= wcnt + 1'b1;
	end

	// kind of the first word decides the burst
	always_ff @(posedge clk) begin
		if (take && (wcnt == '0))
			burst_seg <= rd.word.seg;
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------
	assign rd.rd_en  = take;
	assign o_wr_en   = take;
	assign o_wr_data = rd.word.data;
	assign o_ptr_req = (state == S_PTR);

	assign bus.frame_start = (state == S_PTR) && i_ptr_ack;
	assign bus.req         = (state == S_CMD);
	// count held in S_CMD, so len is stable
	assign bus.len         = wcnt - 1'b1;
	// last command acked, or frame ended right after a command
	assign bus.frame_done  = end_cond
		&& (((state == S_WR) && (wcnt == '0)) || ((state == S_CMD) && bus.ack));

	a_len_max: assert property (@(posedge clk) disable iff (reset)
		bus.req |-> (bus.len <= `FB_BURST_LEN - 1));

	// no word counted while a command waits for the issuer
	a_no_rd_cmd: assert property (@(posedge clk) disable iff (reset)
		(bus.req && !bus.ack) |=> $stable(bus.len));

	// issuer acks once, request drops right after
	a_req_drop: assert property (@(posedge clk) disable iff (reset)
		bus.ack |=> !bus.req);

endmodule

/* verilog/frame_in_fifo.sv */
// front FIFO of the frame buffer
// frame edge, stream enable latch, circular buffer and overflow flag

`include "frame_buf_cfg.svh"

module frame_in_fifo import frame_buf_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_fval,
	input  logic                  i_dval,
	input  seg_kind_t             i_seg,
	input  logic [`FB_DATA_W-1:0] i_data,
	input  logic                  i_stream_enable,
	output logic                  o_full,
	output logic                  o_overflow,
	fifo_rd_if.producer           rd
);
	localparam int AW = $clog2(`FB_FIFO_DEPTH);

	fifo_word_t    mem [`FB_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_addr;
	logic [AW:0]   count;
	logic          fval_q;
	logic          fval_rise;
	logic          stream_on;
	logic          clear;
	logic          wr_req;
	logic          wr_keep;
	logic          rd_take;

	// ----------------------------------------
	// frame edge and stream latch
	// ----------------------------------------
	assign fval_rise = i_fval & ~fval_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			fval_q    <= 1'b0;
			stream_on <= 1'b0;
		end else begin
			fval_q <= i_fval;
			// drop at once, set only at a frame start
			if (!i_stream_enable)
				stream_on <= 1'b0;
			else if (fval_rise)
				stream_on <= 1'b1;
		end
	end

	// ----------------------------------------
	// write / read qualifiers
	// ----------------------------------------
	// new frame or stream off empties the buffer
	assign clear   = fval_rise | ~stream_on;
	assign wr_req  = i_fval & i_dval & ~o_full;
	// word kept only if the stream is on after this edge
	assign wr_keep = wr_req & i_stream_enable & (stream_on | fval_rise);
	assign rd_take = rd.rd_en & ~rd.empty & ~clear;
	// first word of a new frame lands in slot 0
	assign wr_addr = clear ? '0 : wr_ptr;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			rd_ptr <= '0;
			wr_ptr <= {{(AW-1){1'b0}}, wr_keep};
			count  <= {{AW{1'b0}}, wr_keep};
		end else begin
			if (wr_keep)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_take)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + {{AW{1'b0}}, wr_keep} - {{AW{1'b0}}, rd_take};
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (wr_keep)
			mem[wr_addr] <= '{seg: i_seg, data: i_data};
	end

	// sticky until the next frame start
	always_ff @(posedge clk) begin
		if (reset)
			o_overflow <= 1'b0;
		else if (fval_rise)
			o_overflow <= 1'b0;
		else if (i_dval && o_full)
			o_overflow <= 1'b1;
	end

	// ----------------------------------------
	// status toward the writer
	// ----------------------------------------
	assign o_full          = (count == `FB_FIFO_DEPTH);
	assign rd.word         = mem[rd_ptr];
	assign rd.empty        = (count == '0);
	assign rd.level_ok     = (count >= `FB_FIFO_THRESH);
	assign rd.frame_active = fval_q;
	assign rd.stream_on    = stream_on;

	// fill level never runs past the depth
	a_no_wr_full: assert property (@(posedge clk) disable iff (reset)
		count <= `FB_FIFO_DEPTH);

	// writer only pops real data
	a_no_rd_empty: assert property (@(posedge clk) disable iff (reset)
		rd.rd_en |-> !rd.empty);

endmodule

/* verilog/frame_buf_if.sv */
// frame buffer write side
// FIFO read port and burst command handshake

`include "frame_buf_cfg.svh"

// ----------------------------------------
// front FIFO read side, first word fall through
// ----------------------------------------
interface fifo_rd_if import frame_buf_pkg::*; ();
	fifo_word_t word;
	logic       empty;
	// level at or above start threshold
	logic       level_ok;
	// registered fval
	logic       frame_active;
	// latched stream enable
	logic       stream_on;
	// pop, only honoured when not empty
	logic       rd_en;

	modport producer (
		output word, empty, level_ok, frame_active, stream_on,
		input  rd_en
	);

	modport consumer (
		input  word, empty, level_ok, frame_active, stream_on,
		output rd_en
	);
endinterface

// ----------------------------------------
// burst close to command issue
// ----------------------------------------
interface burst_if ();
	// one cycle, new frame slot chosen
	logic               frame_start;
	// held from burst close until ack
	logic               req;
	// words minus one
	logic [`FB_BL_W-1:0] len;
	// frame fully written, pulse
	logic               frame_done;
	// same cycle as the command strobe
	logic               ack;

	modport writer (
		output frame_start, req, len, frame_done,
		input  ack
	);

	modport issuer (
		input  frame_start, req, len, frame_done,
		output ack
	);
endinterface

/* verilog/frame_buf_pkg.sv */
// frame buffer write side
// segment kinds, FIFO word and command address layout

`include "frame_buf_cfg.svh"

package frame_buf_pkg;

	// burst index field takes what slot and offset leave over
	localparam int BURST_IDX_W = `FB_BYTE_ADDR_W - `FB_PTR_W - `FB_OFFSET_W;

	// flag segment of a word
	typedef enum logic [1:0] {
		SEG_LEADER,
		SEG_IMAGE,
		SEG_CHUNK,
		SEG_TRAILER
	} seg_kind_t;

	// front FIFO entry, 66 bits
	typedef struct packed {
		seg_kind_t             seg;
		logic [`FB_DATA_W-1:0] data;
	} fifo_word_t;

	// field view of the byte address
	typedef struct packed {
		logic [`FB_PTR_W-1:0]    slot;
		logic [BURST_IDX_W-1:0]  burst_idx;
		logic [`FB_OFFSET_W-1:0] offset;
	} cmd_addr_fields_t;

	// byte address, flat or split into slot / burst / offset
	typedef union packed {
		logic [`FB_BYTE_ADDR_W-1:0] flat;
		cmd_addr_fields_t           f;
	} cmd_addr_u;

endpackage

/* verilog/frame_buf_cfg.svh */
// frame buffer write side
// sizing constants shared by all blocks

`ifndef FRAME_BUF_CFG_SVH
`define FRAME_BUF_CFG_SVH

// one data word from the sensor path
`define FB_DATA_W 64
// frame slot pointer, up to 4 slots
`define FB_PTR_W 2
// longest burst in words
`define FB_BURST_LEN 32
// command burst length field
`define FB_BL_W 6
// command byte address
`define FB_BYTE_ADDR_W 30
// byte offset inside one burst slot, 32 words of 8 bytes
`define FB_OFFSET_W 8
// front FIFO
`define FB_FIFO_DEPTH 256
`define FB_FIFO_THRESH 32

`endif
